//--- hdl/branch_ctrl_regs.sv
`default_nettype none

module branch_ctrl_regs #(
  parameter jmp_pkg::sel_t CS_RESET = 16'h0008,
  parameter int            CNT_W    = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  jmp_pkg::jmp_redirect_t redir_i,
  output jmp_pkg::sel_t          cs_o,
  output logic [CNT_W-1:0]       mispredict_cnt_o
);

  logic cs_load;
  logic cnt_inc;
  logic cnt_full;

  assign cs_load  = redir_i.valid && redir_i.load_cs;
  assign cnt_full = &mispredict_cnt_o;
  assign cnt_inc  = redir_i.valid && redir_i.mispredict && !cnt_full;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cs_o <= CS_RESET;
    end else if (cs_load) begin
      cs_o <= redir_i.cs;
    end
  end

  // the count sticks at all ones instead of wrapping
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mispredict_cnt_o <= '0;
    end else if (cnt_inc) begin
      mispredict_cnt_o <= mispredict_cnt_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/jmp_pkg.sv
`default_nettype none

package jmp_pkg;

  typedef logic [31:0] addr_t;   // linear address, operand or EIP value
  typedef logic [15:0] sel_t;    // code segment selector
  typedef logic [15:0] opcode_t; // first byte in [15:8], second byte of 0F xx in [7:0]
  typedef logic [7:0]  op_byte_t;
  typedef logic [2:0]  ext_t;    // ModRM reg field
  typedef logic [1:0]  opsize_t;
  typedef logic [5:0]  flags_t;

  localparam opsize_t OPS_32 = 2'd0; // encoding 3 decodes the same way
  localparam opsize_t OPS_16 = 2'd1;
  localparam opsize_t OPS_8  = 2'd2;

  localparam int ZF_BIT = 3;
  localparam int CF_BIT = 1;

  localparam op_byte_t OP_JNE       = 8'h75;
  localparam op_byte_t OP_JNBE      = 8'h77;
  localparam op_byte_t OP_TWO       = 8'h0F;
  localparam op_byte_t OP2_JNE      = 8'h85;
  localparam op_byte_t OP2_JNBE     = 8'h87;
  localparam op_byte_t OP_JMP_REL32 = 8'hE9;
  localparam op_byte_t OP_JMP_REL8  = 8'hEB;
  localparam op_byte_t OP_JMP_FAR   = 8'hEA;
  localparam op_byte_t OP_GRP5      = 8'hFF;

  localparam ext_t FF_JMP_EXT = 3'd4; // FF /4 is the indirect near jump

  typedef struct packed {
    addr_t   eip;        // EIP of the next instruction
    addr_t   op0;        // displacement or absolute target
    sel_t    cs_sel;
    opcode_t opcode;
    ext_t    ext;
    opsize_t opsize;
    flags_t  eflags;
    logic    pred_taken;
  } jmp_uop_t;

  typedef struct packed {
    logic  valid;
    logic  load_addr;
    addr_t addr;
    logic  load_cs;
    sel_t  cs;
    logic  mispredict;
  } jmp_redirect_t;

endpackage

`default_nettype wire

//--- hdl/jump_resolve.sv
`default_nettype none

module jump_resolve (
  input  logic                   uop_valid_i,
  input  jmp_pkg::jmp_uop_t      uop_i,
  input  jmp_pkg::addr_t         rel_addr_i,
  input  jmp_pkg::addr_t         abs_addr_i,
  output jmp_pkg::jmp_redirect_t redir_o
);

  import jmp_pkg::*;

  op_byte_t op_hi;
  op_byte_t op_lo;
  logic     two_byte;
  logic     is_jne;
  logic     is_jnbe;
  logic     is_cond;
  logic     is_rel;
  logic     is_far;
  logic     is_ind;
  logic     is_jump;
  logic     zf;
  logic     cf;
  logic     cond_taken;
  logic     taken;
  addr_t    target;

  assign op_hi = uop_i.opcode[15:8];
  assign op_lo = uop_i.opcode[7:0];

  assign two_byte = (op_hi == OP_TWO);

  // Jcc in short form, or the 0F prefixed near form
  assign is_jne  = (op_hi == OP_JNE)  || (two_byte && (op_lo == OP2_JNE));
  assign is_jnbe = (op_hi == OP_JNBE) || (two_byte && (op_lo == OP2_JNBE));
  assign is_cond = is_jne || is_jnbe;

  assign is_rel = (op_hi == OP_JMP_REL32) || (op_hi == OP_JMP_REL8);
  assign is_far = (op_hi == OP_JMP_FAR);
  assign is_ind = (op_hi == OP_GRP5) && (uop_i.ext == FF_JMP_EXT); // other FF forms are not jumps

  assign is_jump = is_cond || is_rel || is_far || is_ind;

  assign zf = uop_i.eflags[ZF_BIT];
  assign cf = uop_i.eflags[CF_BIT];

  // JNBE needs both flags clear, JNE only looks at ZF
  assign cond_taken = (is_jne && !zf) || (is_jnbe && !zf && !cf);

  assign taken = cond_taken || is_rel || is_far || is_ind;

  always_comb begin
    if (!taken) begin
      target = '0;
    end else if (is_cond || is_rel) begin
      target = rel_addr_i;
    end else begin
      target = abs_addr_i; // far and indirect forms carry the full target in op0
    end
  end

  always_comb begin
    redir_o = '0;
    if (uop_valid_i) begin
      redir_o.valid      = 1'b1;
      redir_o.load_addr  = taken;
      redir_o.addr       = target;
      redir_o.load_cs    = is_far;
      redir_o.cs         = is_far ? uop_i.cs_sel : '0;
      redir_o.mispredict = is_jump && (taken != uop_i.pred_taken);
    end
  end

endmodule

`default_nettype wire

//--- hdl/jump_target.sv
`default_nettype none

module jump_target (
  input  jmp_pkg::addr_t   eip_i,
  input  jmp_pkg::addr_t   op0_i,
  input  jmp_pkg::opsize_t opsize_i,
  output jmp_pkg::addr_t   rel_addr_o,
  output jmp_pkg::addr_t   abs_addr_o
);

  import jmp_pkg::*;

  addr_t near_sum;

  // truncate a target to the operand size of the jump
  function automatic addr_t size_mask(input addr_t target, input addr_t eip,
                                      input opsize_t opsize);
    addr_t masked;
    case (opsize)
      OPS_32:  masked = target;
      OPS_16:  masked = {16'h0000, target[15:0]};
      OPS_8:   masked = {eip[31:8], target[7:0]}; // stays inside the current 256 byte page
      default: masked = target;
    endcase
    return masked;
  endfunction

  // the displacement is already sign extended by decode, so a plain add covers rel8 and rel32
  assign near_sum = eip_i + op0_i;

  assign rel_addr_o = size_mask(near_sum, eip_i, opsize_i);
  assign abs_addr_o = size_mask(op0_i, eip_i, opsize_i);

endmodule

`default_nettype wire

//--- hdl/jump_unit_top.sv
`default_nettype none

module jump_unit_top #(
  parameter jmp_pkg::sel_t CS_RESET = 16'h0008,
  parameter int            CNT_W    = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   uop_valid_i,
  input  jmp_pkg::jmp_uop_t      uop_i,
  output jmp_pkg::jmp_redirect_t redir_o,
  output jmp_pkg::sel_t          cs_o,
  output logic [CNT_W-1:0]       mispredict_cnt_o
);

  import jmp_pkg::*;

  logic          uop_vld_q;
  jmp_uop_t      uop_q;
  addr_t         rel_addr;
  addr_t         abs_addr;
  jmp_redirect_t redir_d;
  jmp_redirect_t redir_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      uop_vld_q <= 1'b0;
    end else begin
      uop_vld_q <= uop_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (uop_valid_i) begin
      uop_q <= uop_i;
    end
  end

  jump_target i_target (
    .eip_i      (uop_q.eip),
    .op0_i      (uop_q.op0),
    .opsize_i   (uop_q.opsize),
    .rel_addr_o (rel_addr),
    .abs_addr_o (abs_addr)
  );

  jump_resolve i_resolve (
    .uop_valid_i (uop_vld_q),
    .uop_i       (uop_q),
    .rel_addr_i  (rel_addr),
    .abs_addr_i  (abs_addr),
    .redir_o     (redir_d)
  );

  // output redirect register, one edge behind the stage register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      redir_q <= '0;
    end else begin
      redir_q <= redir_d;
    end
  end

  assign redir_o = redir_q;

  branch_ctrl_regs #(
    .CS_RESET (CS_RESET),
    .CNT_W    (CNT_W)
  ) i_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .redir_i          (redir_q),
    .cs_o             (cs_o),
    .mispredict_cnt_o (mispredict_cnt_o)
  );

endmodule

`default_nettype wire

//--- jump_unit.f
hdl/jmp_pkg.sv
hdl/jump_target.sv
hdl/jump_resolve.sv
hdl/branch_ctrl_regs.sv
hdl/jump_unit_top.sv
tests/jump_unit_sva.sv
tests/jump_unit_checker.sv
tests/jump_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the jump unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module jump_unit_tb \
  -f jump_unit.f \
  -o jump_unit_sim

# keep running past assertion errors so the testbench prints its summary
./obj_dir/jump_unit_sim +verilator+error+limit+1000 | tee sim.log

if grep -qx "No errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tests/jump_unit_checker.sv
`default_nettype none

module jump_unit_checker #(
  parameter jmp_pkg::sel_t CS_RESET = 16'h0008,
  parameter int            CNT_W    = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   uop_valid_i,
  input  jmp_pkg::jmp_uop_t      uop_i,
  input  jmp_pkg::jmp_redirect_t redir_i,
  input  jmp_pkg::sel_t          cs_i,
  input  logic [CNT_W-1:0]       cnt_i,
  output int unsigned            error_cnt_o,
  output int unsigned            check_cnt_o,
  output int unsigned            redir_cnt_o
);

  import jmp_pkg::*;

  jmp_redirect_t    exp_q[$];  // one entry per cycle, valid or not
  jmp_redirect_t    exp_redir;
  sel_t             exp_cs;
  logic [CNT_W-1:0] exp_cnt;
  int unsigned      error_cnt = 0;
  int unsigned      check_cnt = 0;
  int unsigned      redir_cnt = 0;

  assign error_cnt_o = error_cnt;
  assign check_cnt_o = check_cnt;
  assign redir_cnt_o = redir_cnt;

  function automatic jmp_redirect_t jump_ref(input logic vld, input jmp_uop_t u);
    jmp_redirect_t r;
    logic [7:0]    b0;
    logic [7:0]    b1;
    logic          jne;
    logic          jnbe;
    logic          near_rel;
    logic          far_jmp;
    logic          ind;
    logic          taken;
    addr_t         raw;
    r = '0;
    if (!vld) return r;
    b0 = u.opcode[15:8];
    b1 = u.opcode[7:0];
    jne = (b0 == 8'h75) || ((b0 == 8'h0F) && (b1 == 8'h85));
    jnbe = (b0 == 8'h77) || ((b0 == 8'h0F) && (b1 == 8'h87));
    near_rel = (b0 == 8'hE9) || (b0 == 8'hEB);
    far_jmp = (b0 == 8'hEA);
    ind = (b0 == 8'hFF) && (u.ext == 3'd4);
    if (jne) taken = !u.eflags[3];
    else if (jnbe) taken = !u.eflags[3] && !u.eflags[1];
    else taken = near_rel || far_jmp || ind;
    raw = (far_jmp || ind) ? u.op0 : u.eip + u.op0;
    r.valid = 1'b1;
    r.load_addr = taken;
    if (taken) begin
      case (u.opsize)
        2'd1:    r.addr = {16'h0000, raw[15:0]};
        2'd2:    r.addr = {u.eip[31:8], raw[7:0]}; // page of the next instruction
        default: r.addr = raw;
      endcase
    end
    r.load_cs = far_jmp;
    r.cs = far_jmp ? u.cs_sel : 16'h0000;
    r.mispredict = (jne || jnbe || near_rel || far_jmp || ind) && (taken != u.pred_taken);
    return r;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    check_cnt++;
    if (exp_v !== act_v) begin
      error_cnt++;
      $display("** Error: %s expected %h got %h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  // outputs and inputs are both settled at the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      exp_q.delete();
      exp_cs = CS_RESET;
      exp_cnt = '0;
      check_value("redir_o", 64'(0), 64'(redir_i));
      check_value("cs_o", 64'(CS_RESET), 64'(cs_i));
      check_value("mispredict_cnt_o", 64'(0), 64'(cnt_i));
    end else begin
      check_value("cs_o", 64'(exp_cs), 64'(cs_i));
      check_value("mispredict_cnt_o", 64'(exp_cnt), 64'(cnt_i));
      if (redir_i.valid) redir_cnt++;
      exp_q.push_back(jump_ref(uop_valid_i, uop_i));
      if (exp_q.size() > 2) begin
        exp_redir = exp_q.pop_front();
        check_value("redir_o.valid", 64'(exp_redir.valid), 64'(redir_i.valid));
        check_value("redir_o.load_addr", 64'(exp_redir.load_addr), 64'(redir_i.load_addr));
        check_value("redir_o.addr", 64'(exp_redir.addr), 64'(redir_i.addr));
        check_value("redir_o.load_cs", 64'(exp_redir.load_cs), 64'(redir_i.load_cs));
        check_value("redir_o.cs", 64'(exp_redir.cs), 64'(redir_i.cs));
        check_value("redir_o.mispredict", 64'(exp_redir.mispredict),
                    64'(redir_i.mispredict));
        // register block follows one edge behind the redirect
        if (exp_redir.valid && exp_redir.load_cs) exp_cs = exp_redir.cs;
        if (exp_redir.valid && exp_redir.mispredict && (exp_cnt != '1)) begin
          exp_cnt = exp_cnt + CNT_W'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/jump_unit_sva.sv
`default_nettype none

module jump_unit_sva #(
  parameter int CNT_W = 16
) (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input jmp_pkg::jmp_redirect_t redir_i,
  input logic [CNT_W-1:0]       cnt_i
);

  int unsigned fail_cnt = 0;

  // a far jump always redirects the address as well
  cs_with_addr: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    redir_i.load_cs |-> redir_i.load_addr)
    else begin
      fail_cnt++;
      $error("code segment load without address load");
    end

  idle_packet_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !redir_i.valid |-> (redir_i == '0))
    else begin
      fail_cnt++;
      $error("redirect fields set while valid is low");
    end

  cnt_monotonic: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cnt_i >= $past(cnt_i))
    else begin
      fail_cnt++;
      $error("mispredict counter went down");
    end

endmodule

`default_nettype wire

//--- tests/jump_unit_tb.sv
`default_nettype none

module jump_unit_tb;

  import jmp_pkg::*;

  localparam sel_t CS_RESET = 16'h0010;
  localparam int   CNT_W    = 6;  // narrow enough that the random stream saturates the counter
  localparam int   RAND_OPS = 500;
  // about 60 directed cycles plus 9/8 of the random ops, with headroom
  localparam int   TIMEOUT_CYCLES = 1000;

  logic             clk;
  logic             rst_n;
  logic             uop_valid;
  jmp_uop_t         uop;
  jmp_redirect_t    redir;
  sel_t             cs;
  logic [CNT_W-1:0] mispredict_cnt;
  int unsigned      error_cnt;
  int unsigned      check_cnt;
  int unsigned      redir_cnt;
  int unsigned      sent_cnt = 0;
  int unsigned      cycle_cnt = 0;

  opcode_t cond_ops [4] = '{16'h7500, 16'h77C3, 16'h0F85, 16'h0F87};
  opcode_t op_pool [10] = '{16'h7500, 16'h7700, 16'h0F85, 16'h0F87, 16'hE900,
                            16'hEB00, 16'hEA00, 16'hFF00, 16'h0F84, 16'h9000};

  always #10 clk = ~clk;

  jump_unit_top #(
    .CS_RESET (CS_RESET),
    .CNT_W    (CNT_W)
  ) i_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .uop_valid_i      (uop_valid),
    .uop_i            (uop),
    .redir_o          (redir),
    .cs_o             (cs),
    .mispredict_cnt_o (mispredict_cnt)
  );

  jump_unit_checker #(
    .CS_RESET (CS_RESET),
    .CNT_W    (CNT_W)
  ) i_checker (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .uop_valid_i (uop_valid),
    .uop_i       (uop),
    .redir_i     (redir),
    .cs_i        (cs),
    .cnt_i       (mispredict_cnt),
    .error_cnt_o (error_cnt),
    .check_cnt_o (check_cnt),
    .redir_cnt_o (redir_cnt)
  );

  bind jump_unit_top jump_unit_sva #(
    .CNT_W (CNT_W)
  ) i_sva (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .redir_i (redir_o),
    .cnt_i   (mispredict_cnt_o)
  );

  task automatic finish_run(input logic timed_out);
    int unsigned sva_fails;
    sva_fails = i_dut.i_sva.fail_cnt;
    $display("checks %0d, redirects %0d of %0d, errors %0d, assertion failures %0d",
             check_cnt, redir_cnt, sent_cnt, error_cnt, sva_fails);
    if (timed_out || (error_cnt != 0) || (sva_fails != 0)) begin
      $display("Errors found");
    end else begin
      $display("No errors");
    end
    $finish;
  endtask

  task automatic drive_uop(input opcode_t opc, input ext_t ext, input opsize_t ops,
                           input flags_t fl, input logic pred, input addr_t eip,
                           input addr_t op0, input sel_t sel);
    @(posedge clk);
    #2;
    uop_valid = 1'b1;
    uop.eip = eip;
    uop.op0 = op0;
    uop.cs_sel = sel;
    uop.opcode = opc;
    uop.ext = ext;
    uop.opsize = ops;
    uop.eflags = fl;
    uop.pred_taken = pred;
    sent_cnt++;
  endtask

  // garbage on the bus while valid is low must be ignored
  task automatic idle_cycle();
    @(posedge clk);
    #2;
    uop_valid = 1'b0;
    uop.op0 = $urandom;
    uop.opcode = opcode_t'($urandom);
  endtask

  function automatic flags_t make_flags(input logic zf, input logic cf);
    flags_t fl;
    fl = flags_t'($urandom);
    fl[ZF_BIT] = zf;
    fl[CF_BIT] = cf;
    return fl;
  endfunction

  task automatic run_directed();
    addr_t disp;
    for (int op = 0; op < 4; op++) begin
      for (int f = 0; f < 4; f++) begin
        for (int p = 0; p < 2; p++) begin
          disp = {{24{f[0]}}, 8'($urandom)}; // rel8 style, sign already extended
          drive_uop(cond_ops[op], ext_t'($urandom), OPS_32, make_flags(f[1], f[0]), p[0],
                    $urandom, disp, 16'h0000);
        end
      end
    end
    drive_uop(16'hE900, 3'd0, OPS_32, make_flags(1, 1), 1'b0, 32'h0040_1000, 32'hFFFF_FF00, 16'h0);
    drive_uop(16'hEB00, 3'd0, OPS_32, make_flags(0, 0), 1'b1, 32'h0040_1000, 32'h0000_007F, 16'h0);
    drive_uop(16'hFF00, 3'd4, OPS_32, make_flags(1, 0), 1'b1, 32'h0040_2000, 32'h1234_5678, 16'h0);
    drive_uop(16'hEA00, 3'd0, OPS_32, make_flags(0, 1), 1'b1, 32'h0040_3000, 32'h0000_8000, 16'h0023);
    drive_uop(16'hFF00, 3'd2, OPS_32, make_flags(0, 0), 1'b1, 32'h0040_4000, 32'h0BAD_0000, 16'h0);
    drive_uop(16'h9000, 3'd0, OPS_32, make_flags(0, 0), 1'b0, 32'h0040_5000, 32'h0000_0010, 16'h0);
    drive_uop(16'h0F84, 3'd0, OPS_32, make_flags(0, 0), 1'b1, 32'h0040_6000, 32'h0000_0020, 16'h0);
    idle_cycle();
    idle_cycle();
    drive_uop(16'hEA00, 3'd0, OPS_32, make_flags(0, 0), 1'b0, 32'h0050_0000, 32'h0060_0000, 16'h001B);
    drive_uop(16'hE900, 3'd0, OPS_32, make_flags(0, 0), 1'b1, 32'h0050_1000, 32'h0000_0100, 16'h0077);
    // operand size masking
    drive_uop(16'hE900, 3'd0, OPS_16, make_flags(0, 0), 1'b1, 32'h1234_5678, 32'h0000_9000, 16'h0);
    drive_uop(16'hE900, 3'd0, OPS_8, make_flags(0, 0), 1'b1, 32'h1234_56F0, 32'h0000_0020, 16'h0);
    drive_uop(16'hFF00, 3'd4, OPS_16, make_flags(0, 0), 1'b1, 32'hAABB_CCDD, 32'h8765_4321, 16'h0);
    drive_uop(16'hFF00, 3'd4, OPS_8, make_flags(0, 0), 1'b1, 32'hAABB_CCDD, 32'h8765_4321, 16'h0);
    drive_uop(16'hFF00, 3'd4, 2'd3, make_flags(0, 0), 1'b1, 32'hAABB_CCDD, 32'h8765_4321, 16'h0);
    drive_uop(16'hEA00, 3'd0, OPS_8, make_flags(0, 0), 1'b1, 32'h0101_0101, 32'hFEDC_BA98, 16'h0033);
    drive_uop(16'h7500, 3'd0, OPS_8, make_flags(0, 0), 1'b1, 32'h0070_00FE, 32'h0000_0004, 16'h0);
  endtask

  task automatic drive_random();
    opcode_t opc;
    ext_t    ext;
    opc = op_pool[$urandom_range(0, 9)];
    if (opc[15:8] != OP_TWO) opc[7:0] = 8'($urandom); // second byte is ignored here
    ext = ext_t'($urandom);
    if ((opc[15:8] == OP_GRP5) && ($urandom_range(0, 1) == 0)) ext = FF_JMP_EXT;
    drive_uop(opc, ext, opsize_t'($urandom), flags_t'($urandom), 1'($urandom),
              $urandom, $urandom, sel_t'($urandom));
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: %0d of %0d redirects arrived within %0d cycles",
               redir_cnt, sent_cnt, TIMEOUT_CYCLES);
      finish_run(1'b1);
    end
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    uop_valid = 1'b0;
    uop = '0;
    void'($urandom(63));
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    run_directed();
    for (int i = 0; i < RAND_OPS; i++) begin
      if ($urandom_range(0, 7) == 0) idle_cycle();
      drive_random();
    end
    idle_cycle();
    while (redir_cnt < sent_cnt) @(negedge clk);
    repeat (2) @(negedge clk); // cs_o and the counter trail the last redirect by one edge
    finish_run(1'b0);
  end

endmodule

`default_nettype wire
